// File: Bender.yml
package:
  name: rv_pipe_core

sources:
  - files:
      - verilog/rvIsaPkg.sv
      - verilog/rvPipePkg.sv
      - verilog/rvRegFile.sv
      - verilog/rvBranchPredictor.sv
      - verilog/rvPipeControl.sv
      - verilog/rvHazardUnit.sv
      - verilog/rvPipeDatapath.sv
      - verilog/rvPipeCore.sv
  - target: test
    files:
      - bench/rvPipeCoreTb.sv

// File: bench/rvPipeCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvPipeCoreTb;

    import rvPipePkg::*;

    localparam logic [31:0] ResetPc = resetPcDef;
    localparam int ProgBase   = 'h00;
    localparam int DataBase   = 'h40;
    localparam int CountBase  = 'h50; // Program, data, retire, store counts
    localparam int RetireBase = 'h60;
    localparam int StoreBase  = 'hA0;
    localparam int MaxCycles  = 2000;

    logic        clk;
    logic        reset;
    logic [31:0] pcF, instrF, dataAddr, loadData;
    logic        memWrite, retireValid;
    storeT       store;
    retireT      retire;

    logic [31:0] vec [0:255];
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    retireT      expRetire [0:63];
    storeT       expStore [0:15];
    int numRetires, numStores, retireIdx, storeIdx, checks, cycles;
    int resetErrs, retireErrs, storeErrs, testsFailed;

    rvPipeCore #(
        .ResetPc     (ResetPc),
        .PredIdxBits (5)
    ) rvPipeCore_i (
        .clk           (clk),
        .reset         (reset),
        .pcF_o         (pcF),
        .instrF_i      (instrF),
        .memWrite_o    (memWrite),
        .store_o       (store),
        .dataAddr_o    (dataAddr),
        .loadData_i    (loadData),
        .retireValid_o (retireValid),
        .retire_o      (retire)
    );

    // Combinational memories; fetch outside the image sees a nop
    assign instrF   = (pcF[31:8] == 24'd0) ? imem[pcF[7:2]] : 32'h0000_0013;
    assign loadData = dmem[dataAddr[7:2]]; // 256-byte data space, aliased

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compareRetire(input retireT got);
        retireT want;
        if (retireIdx >= numRetires) begin
            $display("Unexpected retire of x%0d at %0t ns after the expected sequence",
                     got.rd, $time);
            retireErrs++;
        end else begin
            want = expRetire[retireIdx];
            checks++;
            if (got.rd !== want.rd) begin
                $display("ERR %0t ns retire_o.rd expected %0d got %0d", $time, want.rd, got.rd);
                retireErrs++;
            end
            if (got.value !== want.value) begin
                $display("ERR %0t ns retire_o.value expected %h got %h",
                         $time, want.value, got.value);
                retireErrs++;
            end
            retireIdx++;
        end
    endtask

    task automatic compareStore(input storeT got);
        storeT want;
        if (storeIdx >= numStores) begin
            $display("Unexpected store to %h at %0t ns after the expected sequence",
                     got.addr, $time);
            storeErrs++;
        end else begin
            want = expStore[storeIdx];
            checks++;
            if (got.addr !== want.addr) begin
                $display("ERR %0t ns store_o.addr expected %h got %h",
                         $time, want.addr, got.addr);
                storeErrs++;
            end
            if (got.data !== want.data) begin
                $display("ERR %0t ns store_o.data expected %h got %h",
                         $time, want.data, got.data);
                storeErrs++;
            end
            storeIdx++;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (retireValid) compareRetire(retire);
            if (memWrite) begin
                dmem[store.addr[7:2]] = store.data;
                compareStore(store);
            end
        end
    end

    initial begin
        reset       = 1'b1;
        retireIdx   = 0;
        storeIdx    = 0;
        checks      = 0;
        resetErrs   = 0;
        retireErrs  = 0;
        storeErrs   = 0;
        testsFailed = 0;
        $readmemh("bench/rvPipeCoreVectors.txt", vec);
        numRetires = vec[CountBase+2];
        numStores  = vec[CountBase+3];
        for (int i = 0; i < 64; i++) begin
            imem[i] = {12'(i), 20'h00013};     // addi x0, x0, i
            dmem[i] = 32'hDA7A_0000 | (i << 2);
        end
        for (int i = 0; i < vec[CountBase]; i++) imem[i] = vec[ProgBase+i];
        for (int i = 0; i < vec[CountBase+1]; i++) dmem[i] = vec[DataBase+i];
        for (int i = 0; i < numRetires; i++) begin
            expRetire[i] = '{rd: vec[RetireBase+2*i][4:0], value: vec[RetireBase+2*i+1]};
        end
        for (int i = 0; i < numStores; i++) begin
            expStore[i] = '{addr: vec[StoreBase+2*i], data: vec[StoreBase+2*i+1]};
        end
        if ($isunknown(vec[CountBase+3]) || numStores == 0) begin
            $display("Vector file gave no expected stores");
            storeErrs++;
        end

        repeat (10) @(posedge clk);
        #1;
        checks += 3;
        if (pcF !== ResetPc) begin
            $display("ERR %0t ns pcF_o expected %h got %h", $time, ResetPc, pcF);
            resetErrs++;
        end
        if (memWrite !== 1'b0) begin
            $display("ERR %0t ns memWrite_o expected 0 got %b", $time, memWrite);
            resetErrs++;
        end
        if (retireValid !== 1'b0) begin
            $display("ERR %0t ns retireValid_o expected 0 got %b", $time, retireValid);
            resetErrs++;
        end
        $display("reset state: %0d errors, %s", resetErrs, resetErrs == 0 ? "pass" : "fail");
        reset = 1'b0;

        // Run until the final expected store
        cycles = 0;
        while (storeIdx < numStores && cycles < MaxCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (storeIdx < numStores) begin
            $display("Timed out after %0d cycles with %0d of %0d stores seen",
                     cycles, storeIdx, numStores);
            storeErrs++;
        end
        if (retireIdx < numRetires) begin
            $display("Retire stream stopped after %0d of %0d entries", retireIdx, numRetires);
            retireErrs++;
        end
        $display("retire sequence: %0d of %0d entries, %0d errors, %s", retireIdx, numRetires,
                 retireErrs, retireErrs == 0 ? "pass" : "fail");
        $display("store sequence: %0d of %0d entries, %0d errors, %s", storeIdx, numStores,
                 storeErrs, storeErrs == 0 ? "pass" : "fail");
        testsFailed = (resetErrs != 0) + (retireErrs != 0) + (storeErrs != 0);
        $display("Summary: 3 tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 3 - testsFailed, testsFailed, checks, resetErrs + retireErrs + storeErrs);
        if (testsFailed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/rvPipeCoreVectors.txt
// Word sections: @000 program, @040 data image, @050 counts (program, data, retire, store)
// @060 expected retires as rd value pairs, @0A0 expected stores as addr data pairs
@000
123450B7 00500113 FFD10193 00310233
402202B3 0FF2C313 00F37393 1003E413
0032A493 00312533 004375B3 0075E633
002646B3 00402703 001707B3 00F02823
00300813 00000893 010888B3 FFF80813
FE081CE3 01102A23 00C0096F 06300993
06200993 07000A13 000A0AE7 06100993
00310463 02A00B13 01602C23
@040
11111111 00000ABC 22222222 33333333
44444444 55555555 66666666 77777777
@050
0000001F 00000008 0000001B 00000003
@060
00000001 12345000 00000002 00000005 00000003 00000002
00000004 00000007 00000005 00000002 00000006 000000FD
00000007 0000000D 00000008 0000010D 00000009 00000001
0000000A 00000000 0000000B 00000005 0000000C 0000000D
0000000D 00000008 0000000E 00000ABC 0000000F 12345ABC
00000010 00000003 00000011 00000000 00000011 00000003
00000010 00000002 00000011 00000005 00000010 00000001
00000011 00000006 00000010 00000000 00000012 0000005C
00000014 00000070 00000015 0000006C 00000016 0000002A
@0A0
00000010 12345ABC 00000014 00000006 00000018 0000002A

// File: rvPipeCore.f
verilog/rvIsaPkg.sv
verilog/rvPipePkg.sv
verilog/rvRegFile.sv
verilog/rvBranchPredictor.sv
verilog/rvPipeControl.sv
verilog/rvHazardUnit.sv
verilog/rvPipeDatapath.sv
verilog/rvPipeCore.sv
bench/rvPipeCoreTb.sv

// File: verilog/rvBranchPredictor.sv
`timescale 1ns/1ps
`default_nettype none

module rvBranchPredictor #(
    parameter int unsigned PredIdxBits = 5
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            pcF_i,
    input  rvPipePkg::predUpdT     upd_i,
    output logic                   predTaken_o,
    output logic [31:0]            predTarget_o,
    output logic [PredIdxBits-1:0] predIdx_o
);

    localparam int unsigned Entries = 2 ** PredIdxBits;
    localparam int unsigned TagBits = 30 - PredIdxBits;

    logic [1:0]             pht [Entries];
    logic [PredIdxBits-1:0] history;
    logic                   btbValid [Entries];
    logic [TagBits-1:0]     btbTag [Entries];
    logic [31:0]            btbTarget [Entries];
    logic                   btbJump [Entries];

    logic [PredIdxBits-1:0] pcIdx;
    logic                   btbHit;
    logic [PredIdxBits-1:0] updIdx;
    logic [PredIdxBits-1:0] updBtbIdx;
    logic [1:0]             cnt;

    // Fetch side lookup
    assign pcIdx        = pcF_i[PredIdxBits+1:2];
    assign predIdx_o    = pcIdx ^ history;
    assign btbHit       = btbValid[pcIdx] && btbTag[pcIdx] == pcF_i[31:PredIdxBits+2];
    assign predTaken_o  = btbHit && (btbJump[pcIdx] || pht[predIdx_o][1]);
    assign predTarget_o = btbTarget[pcIdx];

    assign updIdx    = upd_i.idx[PredIdxBits-1:0];
    assign updBtbIdx = upd_i.pc[PredIdxBits+1:2];
    assign cnt       = pht[updIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
            for (int i = 0; i < Entries; i++) begin
                pht[i]      <= 2'b01; // Weakly not-taken
                btbValid[i] <= 1'b0;
            end
        end else begin
            if (upd_i.phtWe) begin
                if (upd_i.taken) pht[updIdx] <= (cnt == 2'b11) ? cnt : cnt + 2'b01;
                else pht[updIdx] <= (cnt == 2'b00) ? cnt : cnt - 2'b01;
                history <= upd_i.mispredict ? '0 : {history[PredIdxBits-2:0], upd_i.taken};
            end
            if (upd_i.btbWe) btbValid[updBtbIdx] <= 1'b1;
        end
    end

    // Target buffer payload
    always_ff @(posedge clk) begin
        if (upd_i.btbWe) begin
            btbTag[updBtbIdx]    <= upd_i.pc[31:PredIdxBits+2];
            btbTarget[updBtbIdx] <= upd_i.target;
            btbJump[updBtbIdx]   <= !upd_i.phtWe;
        end
    end

    // Training reads a defined counter
    assert property (@(posedge clk) disable iff (reset)
        upd_i.phtWe |-> !$isunknown(cnt))
        else $error("PHT counter undefined on update");

endmodule

`default_nettype wire

// File: verilog/rvHazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module rvHazardUnit (
    input  logic [4:0]       rs1D_i,
    input  logic [4:0]       rs2D_i,
    input  logic [4:0]       rs1E_i,
    input  logic [4:0]       rs2E_i,
    input  logic [4:0]       rdE_i,
    input  logic [4:0]       rdM_i,
    input  logic [4:0]       rdW_i,
    input  logic             regWriteM_i,
    input  logic             regWriteW_i,
    input  logic             loadE_i,
    input  logic             mispredictE_i,
    output rvIsaPkg::fwdSelT fwdA_o,
    output rvIsaPkg::fwdSelT fwdB_o,
    output logic             stallF_o,
    output logic             stallD_o,
    output logic             flushD_o,
    output logic             flushE_o
);

    import rvIsaPkg::*;

    logic loadUse;

    // Memory stage holds the younger result, so it wins
    always_comb begin
        fwdA_o = fwdReg;
        if (regWriteM_i && rdM_i != 5'd0 && rdM_i == rs1E_i) fwdA_o = fwdMem;
        else if (regWriteW_i && rdW_i != 5'd0 && rdW_i == rs1E_i) fwdA_o = fwdWb;
        fwdB_o = fwdReg;
        if (regWriteM_i && rdM_i != 5'd0 && rdM_i == rs2E_i) fwdB_o = fwdMem;
        else if (regWriteW_i && rdW_i != 5'd0 && rdW_i == rs2E_i) fwdB_o = fwdWb;
    end

    // Consumer right behind a load waits one cycle in decode
    assign loadUse = loadE_i && rdE_i != 5'd0 && (rdE_i == rs1D_i || rdE_i == rs2D_i);

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushD_o = mispredictE_i; // Wrong-path fetch
    assign flushE_o = loadUse || mispredictE_i;

endmodule

`default_nettype wire

// File: verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Major opcodes of the RV32I subset
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immKindT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0, // Also address and jalr target math
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2, // Link value for jal and jalr
        resImm     = 2'd3  // lui
    } resultSelT;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdWb  = 2'd1,
        fwdMem = 2'd2
    } fwdSelT;

endpackage

`default_nettype wire

// File: verilog/rvPipeControl.sv
`timescale 1ns/1ps
`default_nettype none

module rvPipeControl (
    input  logic                clk,
    input  logic                reset,
    input  logic [6:0]          op_i,
    input  logic [2:0]          funct3_i,
    input  logic                funct7b5_i,
    input  logic                stallD_i,
    input  logic                flushE_i,
    output rvIsaPkg::immKindT   immKind_o,
    output rvPipePkg::ctrlExT   ctrlEx_o,
    output rvPipePkg::ctrlMemT  ctrlMem_o,
    output rvPipePkg::ctrlWbT   ctrlWb_o,
    output logic                loadE_o
);

    import rvIsaPkg::*;
    import rvPipePkg::*;

    ctrlExT  exD;
    ctrlMemT memD;
    ctrlMemT memE;

    function automatic aluOpT aluDecode(logic [2:0] f3, logic subOp);
        case (f3)
            3'b000:  return subOp ? aluSub : aluAdd;
            3'b010:  return aluSlt;
            3'b100:  return aluXor;
            3'b110:  return aluOr;
            3'b111:  return aluAnd;
            default: return aluAdd;
        endcase
    endfunction

    // Main decoder; anything unrecognised stays a bubble
    always_comb begin
        immKind_o = immI;
        exD       = '0;
        memD      = '0;
        case (op_i)
            opLui: begin
                immKind_o      = immU;
                memD.regWrite  = 1'b1;
                memD.resultSel = resImm;
            end
            opOpImm, opOp: begin
                exD.aluOp     = aluDecode(funct3_i, op_i == opOp && funct7b5_i);
                exD.aluSrcImm = op_i == opOpImm;
                memD.regWrite = 1'b1;
            end
            opLoad: begin
                exD.aluSrcImm  = 1'b1;
                memD.regWrite  = 1'b1;
                memD.resultSel = resMem;
            end
            opStore: begin
                immKind_o     = immS;
                exD.aluSrcImm = 1'b1;
                memD.memWrite = 1'b1;
            end
            opBranch: begin
                immKind_o    = immB;
                exD.isBranch = 1'b1;
                exD.branchNe = funct3_i[0];
            end
            opJal: begin
                immKind_o      = immJ;
                exD.isJal      = 1'b1;
                memD.regWrite  = 1'b1;
                memD.resultSel = resPcPlus4;
            end
            opJalr: begin
                exD.isJalr     = 1'b1;
                exD.aluSrcImm  = 1'b1;   // rs1 + imm
                memD.regWrite  = 1'b1;
                memD.resultSel = resPcPlus4;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i || stallD_i) begin // Held decode issues a bubble
            ctrlEx_o <= '0;
            memE     <= '0;
        end else begin
            ctrlEx_o <= exD;
            memE     <= memD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlMem_o <= '0;
            ctrlWb_o  <= '0;
        end else begin
            ctrlMem_o <= memE;
            ctrlWb_o  <= '{regWrite: ctrlMem_o.regWrite, resultSel: ctrlMem_o.resultSel};
        end
    end

    assign loadE_o = memE.resultSel == resMem;

endmodule

`default_nettype wire

// File: verilog/rvPipeCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvPipeCore #(
    parameter logic [31:0] ResetPc     = rvPipePkg::resetPcDef,
    parameter int unsigned PredIdxBits = 5
) (
    input  logic              clk,
    input  logic              reset,
    output logic [31:0]       pcF_o,
    input  logic [31:0]       instrF_i,
    output logic              memWrite_o,
    output rvPipePkg::storeT  store_o,
    output logic [31:0]       dataAddr_o,
    input  logic [31:0]       loadData_i,
    output logic              retireValid_o,
    output rvPipePkg::retireT retire_o
);

    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic [6:0]             op;
    logic [2:0]             funct3;
    logic                   funct7b5, loadE, mispredictE;
    logic                   stallF, stallD, flushD, flushE;
    logic [4:0]             rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    immKindT                immKind;
    fwdSelT                 fwdA, fwdB;
    ctrlExT                 ctrlEx;
    ctrlMemT                ctrlMem;
    ctrlWbT                 ctrlWb;
    predUpdT                predUpd;
    logic                   predTaken;
    logic [31:0]            predTarget;
    logic [PredIdxBits-1:0] predIdx;

    rvPipeDatapath #(
        .ResetPc     (ResetPc),
        .PredIdxBits (PredIdxBits)
    ) rvPipeDatapath_i (
        .clk           (clk),
        .reset         (reset),
        .instrF_i      (instrF_i),
        .pcF_o         (pcF_o),
        .predTaken_i   (predTaken),
        .predTarget_i  (predTarget),
        .predIdx_i     (predIdx),
        .predUpd_o     (predUpd),
        .immKind_i     (immKind),
        .ctrlEx_i      (ctrlEx),
        .ctrlMem_i     (ctrlMem),
        .ctrlWb_i      (ctrlWb),
        .stallF_i      (stallF),
        .stallD_i      (stallD),
        .flushD_i      (flushD),
        .flushE_i      (flushE),
        .fwdA_i        (fwdA),
        .fwdB_i        (fwdB),
        .op_o          (op),
        .funct3_o      (funct3),
        .funct7b5_o    (funct7b5),
        .rs1D_o        (rs1D),
        .rs2D_o        (rs2D),
        .rs1E_o        (rs1E),
        .rs2E_o        (rs2E),
        .rdE_o         (rdE),
        .rdM_o         (rdM),
        .rdW_o         (rdW),
        .mispredictE_o (mispredictE),
        .store_o       (store_o),
        .memWrite_o    (memWrite_o),
        .dataAddr_o    (dataAddr_o),
        .loadData_i    (loadData_i),
        .retire_o      (retire_o),
        .retireValid_o (retireValid_o)
    );

    rvPipeControl rvPipeControl_i (
        .clk        (clk),
        .reset      (reset),
        .op_i       (op),
        .funct3_i   (funct3),
        .funct7b5_i (funct7b5),
        .stallD_i   (stallD),
        .flushE_i   (flushE),
        .immKind_o  (immKind),
        .ctrlEx_o   (ctrlEx),
        .ctrlMem_o  (ctrlMem),
        .ctrlWb_o   (ctrlWb),
        .loadE_o    (loadE)
    );

    rvHazardUnit rvHazardUnit_i (
        .rs1D_i        (rs1D),
        .rs2D_i        (rs2D),
        .rs1E_i        (rs1E),
        .rs2E_i        (rs2E),
        .rdE_i         (rdE),
        .rdM_i         (rdM),
        .rdW_i         (rdW),
        .regWriteM_i   (ctrlMem.regWrite),
        .regWriteW_i   (ctrlWb.regWrite),
        .loadE_i       (loadE),
        .mispredictE_i (mispredictE),
        .fwdA_o        (fwdA),
        .fwdB_o        (fwdB),
        .stallF_o      (stallF),
        .stallD_o      (stallD),
        .flushD_o      (flushD),
        .flushE_o      (flushE)
    );

    rvBranchPredictor #(
        .PredIdxBits (PredIdxBits)
    ) rvBranchPredictor_i (
        .clk          (clk),
        .reset        (reset),
        .pcF_i        (pcF_o),
        .upd_i        (predUpd),
        .predTaken_o  (predTaken),
        .predTarget_o (predTarget),
        .predIdx_o    (predIdx)
    );

endmodule

`default_nettype wire

// File: verilog/rvPipeDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module rvPipeDatapath #(
    parameter logic [31:0] ResetPc     = rvPipePkg::resetPcDef,
    parameter int unsigned PredIdxBits = 5
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            instrF_i,
    output logic [31:0]            pcF_o,
    input  logic                   predTaken_i,
    input  logic [31:0]            predTarget_i,
    input  logic [PredIdxBits-1:0] predIdx_i,
    output rvPipePkg::predUpdT     predUpd_o,
    input  rvIsaPkg::immKindT      immKind_i,
    input  rvPipePkg::ctrlExT      ctrlEx_i,
    input  rvPipePkg::ctrlMemT     ctrlMem_i,
    input  rvPipePkg::ctrlWbT      ctrlWb_i,
    input  logic                   stallF_i,
    input  logic                   stallD_i,
    input  logic                   flushD_i,
    input  logic                   flushE_i,
    input  rvIsaPkg::fwdSelT       fwdA_i,
    input  rvIsaPkg::fwdSelT       fwdB_i,
    output logic [6:0]             op_o,
    output logic [2:0]             funct3_o,
    output logic                   funct7b5_o,
    output logic [4:0]             rs1D_o,
    output logic [4:0]             rs2D_o,
    output logic [4:0]             rs1E_o,
    output logic [4:0]             rs2E_o,
    output logic [4:0]             rdE_o,
    output logic [4:0]             rdM_o,
    output logic [4:0]             rdW_o,
    output logic                   mispredictE_o,
    output rvPipePkg::storeT       store_o,
    output logic                   memWrite_o,
    output logic [31:0]            dataAddr_o,
    input  logic [31:0]            loadData_i,
    output rvPipePkg::retireT      retire_o,
    output logic                   retireValid_o
);

    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic [31:0] instrD, pcD, predTargetD, immD, rd1D, rd2D;
    logic        predTakenD;
    logic [PredIdxBits-1:0] predIdxD, predIdxE;
    logic [31:0] pcE, predTargetE, immE, rd1E, rd2E;
    logic        predTakenE;
    logic [31:0] srcAE, writeDataE, srcBE, aluE, pcPlus4E, targetE, correctPcE;
    logic        branchTakenE, takenE;
    logic [31:0] aluM, writeDataM, pcPlus4M, immM, fwdDataM;
    logic [31:0] aluW, readW, pcPlus4W, immW, resultW;

    function automatic logic [31:0] fwdMux(fwdSelT sel, logic [31:0] regVal,
                                           logic [31:0] wbVal, logic [31:0] memVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    // Fetch; a correction from execute beats the prediction
    always_ff @(posedge clk) begin
        if (reset) pcF_o <= ResetPc;
        else if (!stallF_i) begin
            if (mispredictE_o) pcF_o <= correctPcE;
            else if (predTaken_i) pcF_o <= predTarget_i;
            else pcF_o <= pcF_o + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD     <= 32'd0;   // Decodes as a bubble
            predTakenD <= 1'b0;
        end else if (!stallD_i) begin
            instrD      <= instrF_i;
            pcD         <= pcF_o;
            predTakenD  <= predTaken_i;
            predTargetD <= predTarget_i;
            predIdxD    <= predIdx_i;
        end
    end

    // Decode
    assign op_o       = instrD[6:0];
    assign funct3_o   = instrD[14:12];
    assign funct7b5_o = instrD[30];
    assign rs1D_o     = instrD[19:15];
    assign rs2D_o     = instrD[24:20];

    always_comb begin
        case (immKind_i)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    rvRegFile rvRegFile_i (
        .clk      (clk),
        .reset    (reset),
        .rAddr1_i (rs1D_o),
        .rAddr2_i (rs2D_o),
        .wEn_i    (ctrlWb_i.regWrite),
        .wAddr_i  (rdW_o),
        .wData_i  (resultW),
        .rData1_o (rd1D),
        .rData2_o (rd2D)
    );

    always_ff @(posedge clk) begin
        if (reset || flushE_i || stallD_i) predTakenE <= 1'b0;
        else predTakenE <= predTakenD;
    end

    always_ff @(posedge clk) begin
        rd1E        <= rd1D;
        rd2E        <= rd2D;
        pcE         <= pcD;
        immE        <= immD;
        predTargetE <= predTargetD;
        predIdxE    <= predIdxD;
        rs1E_o      <= rs1D_o;
        rs2E_o      <= rs2D_o;
        rdE_o       <= instrD[11:7];
    end

    // Execute
    assign srcAE      = fwdMux(fwdA_i, rd1E, resultW, fwdDataM);
    assign writeDataE = fwdMux(fwdB_i, rd2E, resultW, fwdDataM);
    assign srcBE      = ctrlEx_i.aluSrcImm ? immE : writeDataE;
    assign pcPlus4E   = pcE + 32'd4;

    always_comb begin
        case (ctrlEx_i.aluOp)
            aluSub:  aluE = srcAE - srcBE;
            aluAnd:  aluE = srcAE & srcBE;
            aluOr:   aluE = srcAE | srcBE;
            aluXor:  aluE = srcAE ^ srcBE;
            aluSlt:  aluE = {31'd0, $signed(srcAE) < $signed(srcBE)};
            default: aluE = srcAE + srcBE;
        endcase
    end

    assign branchTakenE = ctrlEx_i.isBranch && ((srcAE == writeDataE) != ctrlEx_i.branchNe);
    assign takenE       = branchTakenE || ctrlEx_i.isJal || ctrlEx_i.isJalr;
    assign targetE      = ctrlEx_i.isJalr ? {aluE[31:1], 1'b0} : pcE + immE;
    assign correctPcE   = takenE ? targetE : pcPlus4E;
    // Wrong direction, or taken to the wrong place
    assign mispredictE_o = (takenE != predTakenE) || (takenE && predTargetE != targetE);

    assign predUpd_o = '{
        phtWe:      ctrlEx_i.isBranch,
        taken:      branchTakenE,
        mispredict: mispredictE_o,
        btbWe:      takenE,
        idx:        PredIdxMaxBits'(predIdxE),
        pc:         pcE,
        target:     targetE
    };

    assert property (@(posedge clk) disable iff (reset)
        takenE |-> targetE[1:0] == 2'b00)
        else $error("Misaligned control transfer target %h", targetE);

    // Memory
    always_ff @(posedge clk) begin
        aluM       <= aluE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        immM       <= immE;
        rdM_o      <= rdE_o;
    end

    assign dataAddr_o = aluM;
    assign memWrite_o = ctrlMem_i.memWrite;
    assign store_o    = '{addr: aluM, data: writeDataM};

    always_comb begin
        case (ctrlMem_i.resultSel)
            resPcPlus4: fwdDataM = pcPlus4M;
            resImm:     fwdDataM = immM;
            default:    fwdDataM = aluM; // Loads never forward from here
        endcase
    end

    // Writeback
    always_ff @(posedge clk) begin
        aluW     <= aluM;
        readW    <= loadData_i;
        pcPlus4W <= pcPlus4M;
        immW     <= immM;
        rdW_o    <= rdM_o;
    end

    always_comb begin
        case (ctrlWb_i.resultSel)
            resMem:     resultW = readW;
            resPcPlus4: resultW = pcPlus4W;
            resImm:     resultW = immW;
            default:    resultW = aluW;
        endcase
    end

    assign retire_o      = '{rd: rdW_o, value: resultW};
    assign retireValid_o = ctrlWb_i.regWrite && rdW_o != 5'd0;

endmodule

`default_nettype wire

// File: verilog/rvPipePkg.sv
`default_nettype none

package rvPipePkg;

    localparam logic [31:0] resetPcDef = 32'h0000_0000;

    // Upper bound on the predictor index carried in update records
    localparam int unsigned PredIdxMaxBits = 12;

    typedef struct packed {
        rvIsaPkg::aluOpT aluOp;
        logic            aluSrcImm;
        logic            isBranch;
        logic            branchNe;  // bne when set, beq otherwise
        logic            isJal;
        logic            isJalr;
    } ctrlExT;

    typedef struct packed {
        logic                memWrite;
        logic                regWrite;
        rvIsaPkg::resultSelT resultSel;
    } ctrlMemT;

    typedef struct packed {
        logic                regWrite;
        rvIsaPkg::resultSelT resultSel;
    } ctrlWbT;

    // Predictor training from the instruction in execute
    typedef struct packed {
        logic                      phtWe;
        logic                      taken;
        logic                      mispredict;
        logic                      btbWe;
        logic [PredIdxMaxBits-1:0] idx;     // Gshare index captured at fetch
        logic [31:0]               pc;      // Selects and tags the target buffer entry
        logic [31:0]               target;
    } predUpdT;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
    } retireT;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } storeT;

endpackage

`default_nettype wire

// File: verilog/rvRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module rvRegFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rAddr1_i,
    input  logic [4:0]  rAddr2_i,
    input  logic        wEn_i,
    input  logic [4:0]  wAddr_i,
    input  logic [31:0] wData_i,
    output logic [31:0] rData1_o,
    output logic [31:0] rData2_o
);

    logic [31:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (wEn_i && wAddr_i != 5'd0) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    always_comb begin
        if (rAddr1_i == 5'd0) rData1_o = 32'd0;
        else if (wEn_i && wAddr_i == rAddr1_i) rData1_o = wData_i;
        else rData1_o = regs[rAddr1_i];
        if (rAddr2_i == 5'd0) rData2_o = 32'd0;
        else if (wEn_i && wAddr_i == rAddr2_i) rData2_o = wData_i;
        else rData2_o = regs[rAddr2_i];
    end

    // Write port fully defined when enabled
    assert property (@(posedge clk) disable iff (reset)
        wEn_i |-> !$isunknown({wAddr_i, wData_i}))
        else $error("Register write with undefined address or data");

endmodule

`default_nettype wire
